// File: sms_clock_pkg.sv
// Constants for the master clock-enable generator
// The 30-cycle phase table and the counter type used to walk it

package sms_clock_pkg;

	typedef logic [4:0] ce_cnt_t;                 // Position inside one enable period

	localparam int unsigned CE_PERIOD = 30;       // clk_sys cycles per period

	// VDP enable, every 5 cycles
	localparam ce_cnt_t VDP_PHASE0 = 5'd4;
	localparam ce_cnt_t VDP_PHASE1 = 5'd9;
	localparam ce_cnt_t VDP_PHASE2 = 5'd14;
	localparam ce_cnt_t VDP_PHASE3 = 5'd19;
	localparam ce_cnt_t VDP_PHASE4 = 5'd24;
	localparam ce_cnt_t VDP_PHASE5 = 5'd29;

	// Pixel enable, every 10 cycles
	localparam ce_cnt_t PIX_PHASE0 = 5'd9;
	localparam ce_cnt_t PIX_PHASE1 = 5'd19;
	localparam ce_cnt_t PIX_PHASE2 = 5'd29;

	localparam ce_cnt_t CPU_PHASE0 = 5'd9;        // CPU enable, every 15 cycles
	localparam ce_cnt_t CPU_PHASE1 = 5'd24;       // Late phase keeps the VDP H counter aligned

endpackage

// File: sms_cart_pkg.sv
// Types and constants of the cartridge path
// Shared by the loader, the arbiter, the store and the top level

package sms_cart_pkg;

	// =====================================================================
	// Data types
	// =====================================================================

	typedef logic [7:0]  rom_byte_t;              // One cartridge byte
	typedef logic [24:0] dl_addr_t;               // Host download address
	typedef logic [7:0]  dl_index_t;              // Host download index

	// =====================================================================
	// Image format
	// =====================================================================

	// Optional copier header in front of the image
	localparam int unsigned HEADER_BYTES = 512;

	// Low five index bits of a Game Gear image
	localparam logic [4:0] GG_INDEX = 5'd2;

	// Index of a code download, not a cartridge
	localparam dl_index_t CODE_INDEX = 8'hff;

endpackage

// File: sms_ce_gen.sv
// Master clock-enable generator for the console core
// One divide-by-30 counter drives the CPU, VDP, pixel and sprite strobes

`timescale 1ns/1ps

module sms_ce_gen (
	input  logic clk_sys,
	input  logic rst,
	output logic ce_cpu,
	output logic ce_vdp,
	output logic ce_pix,
	output logic ce_sp
);

	sms_clock_pkg::ce_cnt_t cnt;
	logic                   cnt_last;
	logic                   hit_vdp;
	logic                   hit_pix;
	logic                   hit_cpu;

	assign cnt_last = (cnt == sms_clock_pkg::ce_cnt_t'(sms_clock_pkg::CE_PERIOD - 1));

	// Phase table lookup
	assign hit_vdp = (cnt == sms_clock_pkg::VDP_PHASE0) || (cnt == sms_clock_pkg::VDP_PHASE1) ||
	                 (cnt == sms_clock_pkg::VDP_PHASE2) || (cnt == sms_clock_pkg::VDP_PHASE3) ||
	                 (cnt == sms_clock_pkg::VDP_PHASE4) || (cnt == sms_clock_pkg::VDP_PHASE5);

	assign hit_pix = (cnt == sms_clock_pkg::PIX_PHASE0) || (cnt == sms_clock_pkg::PIX_PHASE1) ||
	                 (cnt == sms_clock_pkg::PIX_PHASE2);

	assign hit_cpu = (cnt == sms_clock_pkg::CPU_PHASE0) || (cnt == sms_clock_pkg::CPU_PHASE1);

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cnt    <= '0;
			ce_cpu <= 1'b0;
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
			ce_sp  <= 1'b0;
		end else begin
			if (cnt_last) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end

			// Registered so every strobe is one clean cycle
			ce_vdp <= hit_vdp;
			ce_pix <= hit_pix;
			ce_cpu <= hit_cpu;
			ce_sp  <= cnt[0];                     // Half-rate square wave
		end
	end

endmodule

// File: sms_cart_loader.sv
// Cartridge loader on the host download port
// Turns host bytes into toggle write requests, holding the host off with ioctl_wait,
// and learns the mirroring masks, the header flag and the Game Gear flag

`timescale 1ns/1ps

module sms_cart_loader #(
	parameter int ROM_AW = 16
) (
	input  logic                    clk_sys,
	input  logic                    rst,
	input  logic                    ioctl_download,
	input  sms_cart_pkg::dl_index_t ioctl_index,
	input  logic                    ioctl_wr,
	input  sms_cart_pkg::dl_addr_t  ioctl_addr,
	input  sms_cart_pkg::rom_byte_t ioctl_dout,
	input  logic                    wr_ack,
	output logic                    ioctl_wait,
	output logic                    wr_req,
	output logic [ROM_AW-1:0]       wr_addr,
	output sms_cart_pkg::rom_byte_t wr_data,
	output logic [ROM_AW-1:0]       mask,
	output logic [ROM_AW-1:0]       mask_hdr,
	output logic                    has_header,
	output logic                    gg,
	output logic                    loading
);

	typedef logic [ROM_AW-1:0] rom_addr_t;

	localparam rom_addr_t HDR_OFS = rom_addr_t'(sms_cart_pkg::HEADER_BYTES);
	localparam int        HDR_BIT = $clog2(sms_cart_pkg::HEADER_BYTES);

	logic                   cart_dl;
	logic                   cart_wr;
	logic                   dl_prev;
	logic                   dl_rise;
	logic                   dl_fall;
	rom_addr_t              dl_a;
	sms_cart_pkg::dl_addr_t last_addr;
	sms_cart_pkg::dl_addr_t dl_size;

	// Code downloads go elsewhere
	assign cart_dl = ioctl_download && (ioctl_index != sms_cart_pkg::CODE_INDEX);
	assign cart_wr = ioctl_wr && cart_dl;
	assign dl_rise = cart_dl && !dl_prev;
	assign dl_fall = dl_prev && !cart_dl;
	assign dl_a    = ioctl_addr[ROM_AW-1:0];
	assign dl_size = last_addr + 1'b1;      // Bytes seen so far
	assign loading = cart_dl;

	// =====================================================================
	// Write sequencing
	// =====================================================================

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			dl_prev    <= 1'b0;
			ioctl_wait <= 1'b0;
			wr_req     <= 1'b0;
			wr_addr    <= '0;
		end else begin
			dl_prev <= cart_dl;
			if (cart_wr) begin
				ioctl_wait <= 1'b1;
				wr_req     <= ~wr_req;            // Flag a pending write
			end else if (ioctl_wait && (wr_req == wr_ack)) begin
				ioctl_wait <= 1'b0;
				wr_addr    <= wr_addr + 1'b1;
			end
			if (dl_rise) begin
				wr_addr <= '0;                    // New image starts at 0
			end
		end
	end

	// Byte held until the arbiter acknowledges it
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			wr_data <= ioctl_dout;
		end
	end

	// =====================================================================
	// Image properties
	// =====================================================================

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			mask       <= '0;
			mask_hdr   <= '0;
			has_header <= 1'b0;
			gg         <= 1'b0;
			last_addr  <= '0;
		end else begin
			if (cart_wr) begin
				mask      <= (dl_a == '0) ? '0 : (mask | dl_a);
				mask_hdr  <= (dl_a == HDR_OFS) ? '0 : (mask_hdr | (dl_a - HDR_OFS));
				gg        <= (ioctl_index[4:0] == sms_cart_pkg::GG_INDEX);
				last_addr <= ioctl_addr;
			end
			// A header leaves half a KB over whole kilobytes
			if (dl_fall) begin
				has_header <= dl_size[HDR_BIT];
			end
		end
	end

endmodule

// File: sms_rom_arbiter.sv
// Arbiter between console ROM reads and loader writes on one store port
// Reads win; a pending toggle write goes into the first idle cycle

`timescale 1ns/1ps

module sms_rom_arbiter #(
	parameter int ROM_AW = 16
) (
	input  logic                    clk_sys,
	input  logic                    rst,
	input  logic                    rom_rd,
	input  logic [ROM_AW-1:0]       rom_a,
	input  logic                    wr_req,
	input  logic [ROM_AW-1:0]       wr_addr,
	input  sms_cart_pkg::rom_byte_t wr_data,
	input  logic [ROM_AW-1:0]       mask,
	input  logic [ROM_AW-1:0]       mask_hdr,
	input  logic                    has_header,
	input  sms_cart_pkg::rom_byte_t q,
	output sms_cart_pkg::rom_byte_t rom_do,
	output logic                    rom_rdy,
	output logic                    wr_ack,
	output logic [ROM_AW-1:0]       mem_addr,
	output logic                    mem_we,
	output sms_cart_pkg::rom_byte_t mem_d
);

	typedef logic [ROM_AW-1:0] rom_addr_t;

	localparam rom_addr_t HDR_OFS = rom_addr_t'(sms_cart_pkg::HEADER_BYTES);

	rom_addr_t rd_addr;
	logic      wr_pend;
	logic      wr_issued;   // Write done, ack goes out next edge
	logic      rd_v;        // Read in the store stage

	// =====================================================================
	// Address translation and port select
	// =====================================================================

	// Skip the header, then mirror to the image size
	assign rd_addr = has_header ? ((rom_a + HDR_OFS) & mask_hdr) : (rom_a & mask);

	assign wr_pend  = (wr_req != wr_ack);
	assign mem_we   = wr_pend && !rom_rd && !wr_issued;
	assign mem_addr = rom_rd ? rd_addr : wr_addr;
	assign mem_d    = wr_data;

	// =====================================================================
	// Handshake and read pipeline
	// =====================================================================

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wr_ack    <= 1'b0;
			wr_issued <= 1'b0;
			rd_v      <= 1'b0;
			rom_rdy   <= 1'b0;
		end else begin
			rd_v    <= rom_rd;
			rom_rdy <= rd_v;
			if (wr_issued) begin
				wr_ack    <= wr_req;              // Close the toggle
				wr_issued <= 1'b0;
			end else if (mem_we) begin
				wr_issued <= 1'b1;
			end
		end
	end

	// Output register on the store data
	always_ff @(posedge clk_sys) begin
		if (rd_v) begin
			rom_do <= q;
		end
	end

endmodule

// File: sms_rom_store.sv
// Cartridge image store
// Single-port byte RAM, read registered, contents kept across reset

`timescale 1ns/1ps

module sms_rom_store #(
	parameter int ROM_AW = 16
) (
	input  logic                    clk_sys,
	input  logic [ROM_AW-1:0]       addr,
	input  logic                    we,
	input  sms_cart_pkg::rom_byte_t d,
	output sms_cart_pkg::rom_byte_t q
);

	localparam int DEPTH = 2 ** ROM_AW;

	sms_cart_pkg::rom_byte_t mem [0:DEPTH-1];

	always_ff @(posedge clk_sys) begin
		if (we) begin
			mem[addr] <= d;
		end
		q <= mem[addr];                           // Old data on a write cycle
	end

endmodule

// File: sms_cart_top.sv
// Cartridge path top level
// Clock enables plus the loader, arbiter and ROM store behind the host port

`timescale 1ns/1ps

module sms_cart_top #(
	parameter int ROM_AW = 16
) (
	input  logic                    clk_sys,
	input  logic                    rst,
	input  logic                    ioctl_download,
	input  sms_cart_pkg::dl_index_t ioctl_index,
	input  logic                    ioctl_wr,
	input  sms_cart_pkg::dl_addr_t  ioctl_addr,
	input  sms_cart_pkg::rom_byte_t ioctl_dout,
	input  logic                    rom_rd,
	input  logic [ROM_AW-1:0]       rom_a,
	output logic                    ioctl_wait,
	output sms_cart_pkg::rom_byte_t rom_do,
	output logic                    rom_rdy,
	output logic                    gg,
	output logic                    loading,
	output logic                    ce_cpu,
	output logic                    ce_vdp,
	output logic                    ce_pix,
	output logic                    ce_sp
);

	// Loader to arbiter
	logic                    wr_req;
	logic                    wr_ack;
	logic [ROM_AW-1:0]       wr_addr;
	sms_cart_pkg::rom_byte_t wr_data;
	logic [ROM_AW-1:0]       mask;
	logic [ROM_AW-1:0]       mask_hdr;
	logic                    has_header;

	// Arbiter to store
	logic [ROM_AW-1:0]       mem_addr;
	logic                    mem_we;
	sms_cart_pkg::rom_byte_t mem_d;
	sms_cart_pkg::rom_byte_t mem_q;

	sms_ce_gen i_ce_gen (
		.clk_sys (clk_sys),
		.rst     (rst),
		.ce_cpu  (ce_cpu),
		.ce_vdp  (ce_vdp),
		.ce_pix  (ce_pix),
		.ce_sp   (ce_sp)
	);

	sms_cart_loader #(.ROM_AW(ROM_AW)) i_loader (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.wr_ack         (wr_ack),
		.ioctl_wait     (ioctl_wait),
		.wr_req         (wr_req),
		.wr_addr        (wr_addr),
		.wr_data        (wr_data),
		.mask           (mask),
		.mask_hdr       (mask_hdr),
		.has_header     (has_header),
		.gg             (gg),
		.loading        (loading)
	);

	sms_rom_arbiter #(.ROM_AW(ROM_AW)) i_arbiter (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.rom_rd     (rom_rd),
		.rom_a      (rom_a),
		.wr_req     (wr_req),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.mask       (mask),
		.mask_hdr   (mask_hdr),
		.has_header (has_header),
		.q          (mem_q),
		.rom_do     (rom_do),
		.rom_rdy    (rom_rdy),
		.wr_ack     (wr_ack),
		.mem_addr   (mem_addr),
		.mem_we     (mem_we),
		.mem_d      (mem_d)
	);

	sms_rom_store #(.ROM_AW(ROM_AW)) i_store (
		.clk_sys (clk_sys),
		.addr    (mem_addr),
		.we      (mem_we),
		.d       (mem_d),
		.q       (mem_q)
	);

endmodule

// File: tb_sms_cart.sv
// Self-checking testbench for the cartridge path top level
// Loads random images over the host port and reads them back through the console port

`timescale 1ns/1ps

module tb_sms_cart;

	localparam int ROM_AW = 16;

	logic                    clk_sys = 1'b0;
	logic                    rst;
	logic                    ioctl_download;
	sms_cart_pkg::dl_index_t ioctl_index;
	logic                    ioctl_wr;
	sms_cart_pkg::dl_addr_t  ioctl_addr;
	sms_cart_pkg::rom_byte_t ioctl_dout;
	logic                    rom_rd;
	logic [ROM_AW-1:0]       rom_a;
	logic                    ioctl_wait;
	sms_cart_pkg::rom_byte_t rom_do;
	logic                    rom_rdy;
	logic                    gg;
	logic                    loading;
	logic                    ce_cpu;
	logic                    ce_vdp;
	logic                    ce_pix;
	logic                    ce_sp;

	logic [7:0]  image [0:4095];             // Model of the current image
	logic [7:0]  exp_q [$];                  // Expected bytes of reads in flight
	logic [31:0] rng;
	string       test_name;
	int          errors;
	int          reads_checked;
	int          done_count;                 // Bytes acknowledged in this download
	logic        dl_busy;
	logic        rd_sent1;
	logic        rd_sent2;

	sms_cart_top #(.ROM_AW(ROM_AW)) i_dut (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.rom_rd         (rom_rd),
		.rom_a          (rom_a),
		.ioctl_wait     (ioctl_wait),
		.rom_do         (rom_do),
		.rom_rdy        (rom_rdy),
		.gg             (gg),
		.loading        (loading),
		.ce_cpu         (ce_cpu),
		.ce_vdp         (ce_vdp),
		.ce_pix         (ce_pix),
		.ce_sp          (ce_sp)
	);

	always #20 clk_sys = ~clk_sys;

	// ======================================================================
	// Reference model and helpers
	// ======================================================================

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Byte the console should see at address a
	function automatic logic [7:0] expected_byte(input int a, input int size, input bit hdr);
		int n;
		int m;
		n = hdr ? size - 512 : size;
		m = 0;
		while (m < n - 1) begin
			m = (m << 1) | 1;                    // OR of all addresses below n
		end
		return hdr ? image[(a + 512) & m] : image[a & m];
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		errors++;
		$display("ERROR %s: expected %0d actual %0d", name, expected, actual);
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("ERROR %s", what);
	endtask

	task automatic timeout_fail(input string what);
		errors++;
		$display("Timeout waiting for %s", what);
		$display("Reads checked: %0d, errors: %0d", reads_checked, errors);
		$display("FAIL: see errors above");
		$finish;
	endtask

	task automatic make_image(input int size);
		for (int i = 0; i < size; i++) begin
			rng = lcg_step(rng);
			image[i] = rng[23:16];
		end
	endtask

	// One host byte, then hold off until ioctl_wait drops
	task automatic write_byte(input int addr, input logic [7:0] data);
		int n;
		@(posedge clk_sys);
		ioctl_wr   <= 1'b1;
		ioctl_addr <= sms_cart_pkg::dl_addr_t'(addr);
		ioctl_dout <= data;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		@(posedge clk_sys);
		if (ioctl_wait !== 1'b1) report_failure("ioctl_wait did not rise after a write");
		n = 0;
		while (ioctl_wait === 1'b1) begin
			@(posedge clk_sys);
			n++;
			if (n > 1000) timeout_fail("ioctl_wait to fall");
		end
	endtask

	task automatic download_image(input int size, input logic [7:0] index);
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		ioctl_index    <= index;
		@(posedge clk_sys);
		if (loading !== 1'b1) report_failure("loading low during a cartridge download");
		for (int i = 0; i < size; i++) begin
			write_byte(i, image[i]);
			done_count <= i + 1;
		end
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		repeat (2) @(posedge clk_sys);
		if (loading !== 1'b0) report_failure("loading still high after the download ended");
		dl_busy <= 1'b0;
	endtask

	task automatic wait_reads_done;
		int n;
		n = 0;
		while (exp_q.size() != 0) begin
			@(posedge clk_sys);
			n++;
			if (n > 20) timeout_fail("outstanding read data");
		end
	endtask

	// Back-to-back reads over [first, last)
	task automatic read_range(input string name, input int first, input int last,
		input int size, input bit hdr);
		test_name = name;
		for (int a = first; a < last; a++) begin
			@(posedge clk_sys);
			rom_rd <= 1'b1;
			rom_a  <= a[ROM_AW-1:0];
			exp_q.push_back(expected_byte(a, size, hdr));
		end
		@(posedge clk_sys);
		rom_rd <= 1'b0;
		wait_reads_done();
	endtask

	// Random reads of bytes already acknowledged, while a download runs
	task automatic random_reads;
		int n;
		int a;
		n = 0;
		@(posedge clk_sys);
		while (dl_busy) begin
			rng = lcg_step(rng);
			if (rng[20] && done_count > 0) begin
				a = int'(rng[30:8]) % done_count;
				rom_rd <= 1'b1;
				rom_a  <= a[ROM_AW-1:0];
				exp_q.push_back(expected_byte(a, 1024, 1'b0));
			end else begin
				rom_rd <= 1'b0;
			end
			@(posedge clk_sys);
			n++;
			if (n > 200000) timeout_fail("download under read traffic");
		end
		rom_rd <= 1'b0;
	endtask

	task automatic check_enables;
		int last_vdp;
		int last_pix;
		int last_cpu;
		int n_vdp;
		int n_pix;
		int n_cpu;
		logic prev_sp;
		last_vdp = -1;
		last_pix = -1;
		last_cpu = -1;
		n_vdp = 0;
		n_pix = 0;
		n_cpu = 0;
		prev_sp = 1'b0;
		for (int c = 0; c < 90; c++) begin
			@(posedge clk_sys);
			if (ce_vdp) begin
				if (last_vdp >= 0 && c - last_vdp != 5) begin
					report_mismatch("ce_vdp spacing", 5, c - last_vdp);
				end
				last_vdp = c;
				n_vdp++;
			end
			if (ce_pix) begin
				if (last_pix >= 0 && c - last_pix != 10) begin
					report_mismatch("ce_pix spacing", 10, c - last_pix);
				end
				last_pix = c;
				n_pix++;
			end
			if (ce_cpu) begin
				if (last_cpu >= 0 && c - last_cpu != 15) begin
					report_mismatch("ce_cpu spacing", 15, c - last_cpu);
				end
				last_cpu = c;
				n_cpu++;
			end
			if (c > 0 && ce_sp === prev_sp) report_failure("ce_sp did not toggle");
			prev_sp = ce_sp;
		end
		if (n_vdp != 18) report_mismatch("ce_vdp count", 18, n_vdp);
		if (n_pix != 9) report_mismatch("ce_pix count", 9, n_pix);
		if (n_cpu != 6) report_mismatch("ce_cpu count", 6, n_cpu);
	endtask

	// ======================================================================
	// Read data compare, two cycles after each strobe
	// ======================================================================

	always @(posedge clk_sys) begin
		if (!rst) begin
			if (rom_rdy !== rd_sent2) begin
				report_failure("rom_rdy not 2 cycles after its strobe");
			end
			if (rom_rdy === 1'b1) begin
				if (exp_q.size() == 0) begin
					report_failure("rom_rdy with no read outstanding");
				end else begin
					reads_checked++;
					if (rom_do !== exp_q[0]) report_mismatch(test_name, exp_q[0], rom_do);
					void'(exp_q.pop_front());
				end
			end
		end
		rd_sent2 = rd_sent1;
		rd_sent1 = rom_rd;
	end

	initial begin
		rst            = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		rom_rd         = 1'b0;
		rom_a          = '0;
		rng            = 32'd8;
		errors         = 0;
		reads_checked  = 0;
		done_count     = 0;
		dl_busy        = 1'b0;
		rd_sent1       = 1'b0;
		rd_sent2       = 1'b0;
		test_name      = "idle";

		repeat (4) @(posedge clk_sys);
		rst <= 1'b0;
		repeat (2) @(posedge clk_sys);
		if (ioctl_wait !== 1'b0) report_failure("ioctl_wait high after reset");
		check_enables();

		// Plain 1 KB image with the Game Gear index
		make_image(1024);
		download_image(1024, 8'd2);
		if (gg !== 1'b1) report_mismatch("gg after index 2", 1, gg);
		read_range("plain readback", 0, 1024, 1024, 1'b0);
		read_range("mirror", 1024, 4096, 1024, 1'b0);

		// New image loaded under random read traffic
		make_image(1024);
		test_name  = "contention";
		done_count = 0;
		dl_busy    = 1'b1;
		fork
			download_image(1024, 8'd1);
			random_reads();
		join
		wait_reads_done();
		if (gg !== 1'b0) report_mismatch("gg after index 1", 0, gg);
		read_range("contention readback", 0, 1024, 1024, 1'b0);

		// 512 byte header in front of 2 KB
		make_image(2560);
		download_image(2560, 8'd1);
		read_range("header", 0, 4096, 2560, 1'b1);

		$display("Reads checked: %0d, errors: %0d", reads_checked, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: sources.f
sms_clock_pkg.sv
sms_cart_pkg.sv
sms_ce_gen.sv
sms_cart_loader.sv
sms_rom_arbiter.sv
sms_rom_store.sv
sms_cart_top.sv
tb_sms_cart.sv

// File: Bender.yml
package:
  name: sms_cart

sources:
  - sms_clock_pkg.sv
  - sms_cart_pkg.sv
  - sms_ce_gen.sv
  - sms_cart_loader.sv
  - sms_rom_arbiter.sv
  - sms_rom_store.sv
  - sms_cart_top.sv
  - target: test
    files:
      - tb_sms_cart.sv
